// File: hdl/branchResolver.sv
// Branch condition resolver
`timescale 1ns/1ps
module branchResolver (
	input  decodePkg::instrClassT instrClass,
	input  decodePkg::condT       cond,
	input  decodePkg::flagsT      flags,
	output decodePkg::branchCtrlT branchCtrl
);

	import decodePkg::*;

	logic taken;

	// ARM condition rules
	always_comb begin
		case (cond)
			condEq:  taken = flags.z;
			condNe:  taken = !flags.z;
			condCs:  taken = flags.c;
			condCc:  taken = !flags.c;
			condMi:  taken = flags.n;
			condPl:  taken = !flags.n;
			condVs:  taken = flags.v;
			condVc:  taken = !flags.v;
			condHi:  taken = flags.c && !flags.z;
			condLs:  taken = !flags.c || flags.z;
			condGe:  taken = (flags.n == flags.v);
			condLt:  taken = (flags.n != flags.v);
			condGt:  taken = !flags.z && (flags.n == flags.v);
			condLe:  taken = flags.z || (flags.n != flags.v);
			condAl:  taken = 1'b1;
			// Cond 15 never arrives as a conditional branch
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		branchCtrl = '0;
		case (instrClass)
			clsBcond: begin
				branchCtrl.branch = 1'b1;
				branchCtrl.brSel  = taken ? brCondTarget : brSequential;
			end
			clsB: begin
				branchCtrl.branch = 1'b1;
				branchCtrl.brSel  = brUncondTarget;
			end
			clsBl: begin
				branchCtrl.branch = 1'b1;
				branchCtrl.brSel  = brLink;
			end
			// Target comes from a register, PC steering is the same as BL
			clsBx: begin
				branchCtrl.branch = 1'b1;
				branchCtrl.brSel  = brLink;
				branchCtrl.brEx   = 1'b1;
			end
			clsUnknown: begin
			end
			default: branchCtrl.brSel = brSequential;
		endcase
	end

endmodule

// File: hdl/cpuControl.sv
// CPU decode control unit
`timescale 1ns/1ps
module cpuControl (
	input  logic                  clk,
	input  logic                  rstN,
	input  decodePkg::instrT      instr,
	input  decodePkg::flagsT      flags,
	output decodePkg::dataCtrlT   dataCtrl,
	output decodePkg::branchCtrlT branchCtrl
);

	import decodePkg::*;

	instrClassT instrClass;
	dataCtrlT   dataNext;
	branchCtrlT branchNext;

	opcodeClassifier classifier (
		.clk        (clk),
		.instr      (instr),
		.instrClass (instrClass)
	);

	dataOpDecoder dataDecoder (
		.instrClass (instrClass),
		.dataCtrl   (dataNext)
	);

	// Cond field sits in bits 11 to 8 of a conditional branch
	branchResolver resolver (
		.instrClass (instrClass),
		.cond       (instr[11:8]),
		.flags      (flags),
		.branchCtrl (branchNext)
	);

	// Decode stage boundary, one cycle after the instruction is sampled
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dataCtrl   <= '0;
			branchCtrl <= '0;
		end else begin
			dataCtrl   <= dataNext;
			branchCtrl <= branchNext;
		end
	end

	// Exchange only makes sense on a taken branch path
	brExNeedsBranch: assert property (@(posedge clk) disable iff (!rstN)
		branchCtrl.brEx |-> branchCtrl.branch)
		else $error("brEx set without branch");

endmodule

// File: hdl/dataOpDecoder.sv
// Datapath control decoder
`timescale 1ns/1ps
module dataOpDecoder (
	input  decodePkg::instrClassT instrClass,
	output decodePkg::dataCtrlT   dataCtrl
);

	import decodePkg::*;

	always_comb begin
		// Unused fields stay zero
		dataCtrl = '0;

		case (instrClass)
			clsMovs: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.keepFlags = keepNz;
				dataCtrl.reg3Loc   = 2'd2;
				dataCtrl.selWrData = wrImmOrLink;
			end
			clsMov: begin
				dataCtrl.regWrite  = 1'b1;
				// Plain move leaves the flags alone
				dataCtrl.keepFlags = keepNone;
				dataCtrl.reg2Loc   = 2'd3;
				dataCtrl.aluOp     = aluMov;
				dataCtrl.selWrData = wrAlu;
			end

			// Flag-setting add and subtract
			clsAddsImm, clsAddsReg, clsSubsImm, clsSubsReg: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.keepFlags = keepAll;
				dataCtrl.reg1Loc   = 2'd1;
				dataCtrl.selOpB    = (instrClass inside {clsAddsImm, clsSubsImm}) ?
					opBImm3 : opBReg;
				dataCtrl.aluOp     = (instrClass inside {clsSubsImm, clsSubsReg}) ?
					aluSub : aluAdd;
				dataCtrl.selWrData = wrAlu;
			end

			// SP-relative, no flag update
			clsAddSp, clsSubSp: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.reg3Loc   = 2'd1;
				dataCtrl.selOpB    = opBImmSp;
				dataCtrl.aluOp     = (instrClass == clsSubSp) ? aluSub : aluAdd;
				dataCtrl.selWrData = wrAlu;
			end

			clsCmp: begin
				dataCtrl.keepFlags = keepAll;
				dataCtrl.reg1Loc   = 2'd2;
				dataCtrl.reg2Loc   = 2'd1;
				dataCtrl.aluOp     = aluSub;
			end

			clsAnds, clsEors, clsOrrs, clsMvns: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.keepFlags = keepNz;
				dataCtrl.reg1Loc   = 2'd1;
				dataCtrl.reg2Loc   = 2'd2;
				dataCtrl.selWrData = wrAlu;
				case (instrClass)
					clsAnds: dataCtrl.aluOp = aluAnd;
					clsEors: dataCtrl.aluOp = aluEor;
					clsOrrs: dataCtrl.aluOp = aluOrr;
					default: dataCtrl.aluOp = aluMvn;
				endcase
			end

			// Shifter result bypasses the ALU
			clsLsls, clsLsrs, clsAsrs, clsRors: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.keepFlags = keepNz;
				dataCtrl.reg1Loc   = 2'd1;
				dataCtrl.reg2Loc   = 2'd2;
				dataCtrl.selWrData = wrShifter;
				case (instrClass)
					clsLsls: dataCtrl.shiftDir = shLsl;
					clsLsrs: dataCtrl.shiftDir = shLsr;
					clsAsrs: dataCtrl.shiftDir = shAsr;
					default: dataCtrl.shiftDir = shRor;
				endcase
			end

			clsStr: begin
				dataCtrl.memWrite  = 1'b1;
				dataCtrl.keepFlags = keepNz;
				dataCtrl.reg1Loc   = 2'd1;
				dataCtrl.reg2Loc   = 2'd2;
				dataCtrl.selOpB    = opBImm5;
			end
			clsLdr: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.memRead   = 1'b1;
				dataCtrl.keepFlags = keepNz;
				dataCtrl.reg1Loc   = 2'd1;
				dataCtrl.selOpB    = opBImm5;
				dataCtrl.selWrData = wrMem;
			end

			// Link register write for BL, target register read for BX
			clsBl: begin
				dataCtrl.regWrite  = 1'b1;
				dataCtrl.reg3Loc   = 2'd3;
				dataCtrl.selWrData = wrImmOrLink;
			end
			clsBx: begin
				dataCtrl.reg2Loc   = 2'd3;
			end
			default: begin
			end
		endcase

		memExclusive: assert #0 (!(dataCtrl.memWrite && dataCtrl.memRead))
			else $error("Load and store strobes both set for class %s", instrClass.name());
	end

endmodule

// File: hdl/decodePkg.sv
// Instruction decode definitions
package decodePkg;

	// Instruction bits matched against the opcode patterns
	localparam int opcodeWidth = 10;

	typedef logic [15:0] instrT;

	// Same bit order as the processor status flags, n is the MSB
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} flagsT;

	typedef logic [3:0] condT;
	localparam condT condEq = 4'd0;
	localparam condT condNe = 4'd1;
	localparam condT condCs = 4'd2;
	localparam condT condCc = 4'd3;
	localparam condT condMi = 4'd4;
	localparam condT condPl = 4'd5;
	localparam condT condVs = 4'd6;
	localparam condT condVc = 4'd7;
	localparam condT condHi = 4'd8;
	localparam condT condLs = 4'd9;
	localparam condT condGe = 4'd10;
	localparam condT condLt = 4'd11;
	localparam condT condGt = 4'd12;
	localparam condT condLe = 4'd13;
	localparam condT condAl = 4'd14;

	typedef enum logic [4:0] {
		clsUnknown, clsMovs, clsMov,
		clsAddsImm, clsAddsReg, clsAddSp,
		clsSubsImm, clsSubsReg, clsSubSp,
		clsCmp, clsAnds, clsEors, clsOrrs, clsMvns,
		clsLsls, clsLsrs, clsAsrs, clsRors,
		clsStr, clsLdr,
		clsBcond, clsB, clsBl, clsBx, clsNoop
	} instrClassT;

	// Which instruction bits carry a register number
	typedef logic [1:0] regLocT;

	typedef logic [2:0] aluOpT;
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluSub = 3'd1;
	localparam aluOpT aluAnd = 3'd2;
	localparam aluOpT aluOrr = 3'd3;
	localparam aluOpT aluEor = 3'd4;
	localparam aluOpT aluMvn = 3'd5;
	localparam aluOpT aluMov = 3'd6;

	typedef logic [1:0] shiftDirT;
	localparam shiftDirT shLsl = 2'd0;
	localparam shiftDirT shLsr = 2'd1;
	localparam shiftDirT shAsr = 2'd2;
	localparam shiftDirT shRor = 2'd3;

	typedef logic [2:0] opBSrcT;
	localparam opBSrcT opBReg   = 3'd0;
	localparam opBSrcT opBImm3  = 3'd1;
	localparam opBSrcT opBImmSp = 3'd2;
	localparam opBSrcT opBImm5  = 3'd3;

	typedef logic [1:0] wrSrcT;
	localparam wrSrcT wrShifter   = 2'd0;
	localparam wrSrcT wrAlu       = 2'd1;
	localparam wrSrcT wrImmOrLink = 2'd2;
	localparam wrSrcT wrMem       = 2'd3;

	typedef logic [1:0] brSelT;
	localparam brSelT brLink         = 2'd0;
	localparam brSelT brCondTarget   = 2'd1;
	localparam brSelT brUncondTarget = 2'd2;
	localparam brSelT brSequential   = 2'd3;

	// Update mask in n, z, c, v order
	typedef logic [3:0] flagMaskT;
	localparam flagMaskT keepNone = 4'b0000;
	localparam flagMaskT keepNz   = 4'b1100;
	localparam flagMaskT keepAll  = 4'b1111;

	typedef struct packed {
		logic     regWrite;
		logic     memWrite;
		logic     memRead;
		flagMaskT keepFlags;
		regLocT   reg1Loc;
		regLocT   reg2Loc;
		regLocT   reg3Loc;
		logic     selOpA;
		opBSrcT   selOpB;
		aluOpT    aluOp;
		shiftDirT shiftDir;
		wrSrcT    selWrData;
	} dataCtrlT;

	typedef struct packed {
		logic  branch;
		brSelT brSel;
		logic  brEx;
	} branchCtrlT;

	// Opcode patterns on the top instruction bits, ? marks operand bits
	localparam logic [opcodeWidth-1:0] opMovs    = 10'b00100?????;
	localparam logic [opcodeWidth-1:0] opMov     = 10'b010001100?;
	localparam logic [opcodeWidth-1:0] opAddsImm = 10'b0001110???;
	localparam logic [opcodeWidth-1:0] opAddsReg = 10'b0001100???;
	localparam logic [opcodeWidth-1:0] opAddSp   = 10'b101100000?;
	localparam logic [opcodeWidth-1:0] opSubsImm = 10'b0001111???;
	localparam logic [opcodeWidth-1:0] opSubsReg = 10'b0001101???;
	localparam logic [opcodeWidth-1:0] opSubSp   = 10'b101100001?;
	localparam logic [opcodeWidth-1:0] opCmp     = 10'b0100001010;
	localparam logic [opcodeWidth-1:0] opAnds    = 10'b0100000000;
	localparam logic [opcodeWidth-1:0] opEors    = 10'b0100000001;
	localparam logic [opcodeWidth-1:0] opOrrs    = 10'b0100001100;
	localparam logic [opcodeWidth-1:0] opMvns    = 10'b0100001111;
	localparam logic [opcodeWidth-1:0] opLsls    = 10'b0100000010;
	localparam logic [opcodeWidth-1:0] opLsrs    = 10'b0100000011;
	localparam logic [opcodeWidth-1:0] opAsrs    = 10'b0100000100;
	localparam logic [opcodeWidth-1:0] opRors    = 10'b0100000111;
	localparam logic [opcodeWidth-1:0] opStr     = 10'b01100?????;
	localparam logic [opcodeWidth-1:0] opLdr     = 10'b01101?????;
	localparam logic [opcodeWidth-1:0] opBcond   = 10'b1101??????;
	localparam logic [opcodeWidth-1:0] opB       = 10'b11100?????;
	localparam logic [opcodeWidth-1:0] opBl      = 10'b0100010100;
	localparam logic [opcodeWidth-1:0] opBx      = 10'b010001110?;
	localparam logic [opcodeWidth-1:0] opNoop    = 10'b1011111100;

endpackage

// File: hdl/opcodeClassifier.sv
// Opcode classifier
`timescale 1ns/1ps
module opcodeClassifier (
	// Only used to sample the decode check
	input  logic                  clk,
	input  decodePkg::instrT      instr,
	output decodePkg::instrClassT instrClass
);

	import decodePkg::*;

	logic [opcodeWidth-1:0] opcode;

	assign opcode = instr[15:16-opcodeWidth];

	// First matching pattern wins
	always_comb begin
		priority casez (opcode)
			opMovs:    instrClass = clsMovs;
			opMov:     instrClass = clsMov;
			opAddsImm: instrClass = clsAddsImm;
			opAddsReg: instrClass = clsAddsReg;
			opAddSp:   instrClass = clsAddSp;
			opSubsImm: instrClass = clsSubsImm;
			opSubsReg: instrClass = clsSubsReg;
			opSubSp:   instrClass = clsSubSp;
			opCmp:     instrClass = clsCmp;

			// Logical group
			opAnds:    instrClass = clsAnds;
			opEors:    instrClass = clsEors;
			opOrrs:    instrClass = clsOrrs;
			opMvns:    instrClass = clsMvns;

			// Register-controlled shifts
			opLsls:    instrClass = clsLsls;
			opLsrs:    instrClass = clsLsrs;
			opAsrs:    instrClass = clsAsrs;
			opRors:    instrClass = clsRors;

			opStr:     instrClass = clsStr;
			opLdr:     instrClass = clsLdr;

			// Cond field of all ones is not a valid branch
			opBcond: begin
				if (instr[11:8] != 4'hF) begin
					instrClass = clsBcond;
				end else begin
					instrClass = clsUnknown;
				end
			end
			opB:       instrClass = clsB;
			opBl:      instrClass = clsBl;
			opBx:      instrClass = clsBx;
			opNoop:    instrClass = clsNoop;
			default:   instrClass = clsUnknown;
		endcase
	end

	// Every real conditional branch must reach the branch resolver
	bcondKnown: assert property (@(posedge clk)
		(instr[15:12] == 4'b1101 && instr[11:8] != 4'hF) |-> instrClass != clsUnknown)
		else $error("Conditional branch 0x%h decoded as unknown", instr);

endmodule

// File: verification/controlTests.svh
// Directed decode tests
`ifndef CONTROL_TESTS_SVH
`define CONTROL_TESTS_SVH

// One row of the datapath control table, strobes are regWrite, memWrite, memRead
function automatic dataCtrlT dataRow(input logic [2:0] strobes, input flagMaskT keep,
		input regLocT r1, input regLocT r2, input regLocT r3, input opBSrcT opB,
		input aluOpT alu, input shiftDirT sh, input wrSrcT wr);
	dataRow = '{strobes[2], strobes[1], strobes[0], keep, r1, r2, r3, 1'b0, opB, alu, sh, wr};
endfunction

function automatic ctrlWordT expectedWord(input instrClassT cls, input condT cond,
		input flagsT f);
	ctrlWordT w;
	logic base;
	w = '0;
	case (cls)
		clsMovs:    w.data = dataRow(3'b100, keepNz, '0, '0, 2'd2, '0, '0, '0, wrImmOrLink);
		clsMov:     w.data = dataRow(3'b100, '0, '0, 2'd3, '0, '0, aluMov, '0, wrAlu);
		clsAddsImm: w.data = dataRow(3'b100, keepAll, 2'd1, '0, '0, opBImm3, aluAdd, '0, wrAlu);
		clsAddsReg: w.data = dataRow(3'b100, keepAll, 2'd1, '0, '0, opBReg, aluAdd, '0, wrAlu);
		clsSubsImm: w.data = dataRow(3'b100, keepAll, 2'd1, '0, '0, opBImm3, aluSub, '0, wrAlu);
		clsSubsReg: w.data = dataRow(3'b100, keepAll, 2'd1, '0, '0, opBReg, aluSub, '0, wrAlu);
		clsAddSp:   w.data = dataRow(3'b100, '0, '0, '0, 2'd1, opBImmSp, aluAdd, '0, wrAlu);
		clsSubSp:   w.data = dataRow(3'b100, '0, '0, '0, 2'd1, opBImmSp, aluSub, '0, wrAlu);
		clsCmp:     w.data = dataRow(3'b000, keepAll, 2'd2, 2'd1, '0, '0, aluSub, '0, '0);
		clsAnds:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, aluAnd, '0, wrAlu);
		clsEors:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, aluEor, '0, wrAlu);
		clsOrrs:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, aluOrr, '0, wrAlu);
		clsMvns:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, aluMvn, '0, wrAlu);
		clsLsls:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, '0, shLsl, wrShifter);
		clsLsrs:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, '0, shLsr, wrShifter);
		clsAsrs:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, '0, shAsr, wrShifter);
		clsRors:    w.data = dataRow(3'b100, keepNz, 2'd1, 2'd2, '0, '0, '0, shRor, wrShifter);
		clsStr:     w.data = dataRow(3'b010, keepNz, 2'd1, 2'd2, '0, opBImm5, '0, '0, '0);
		clsLdr:     w.data = dataRow(3'b101, keepNz, 2'd1, '0, '0, opBImm5, '0, '0, wrMem);
		clsBl:      w.data = dataRow(3'b100, '0, '0, '0, 2'd3, '0, '0, '0, wrImmOrLink);
		clsBx:      w.data = dataRow(3'b000, '0, '0, 2'd3, '0, '0, '0, '0, '0);
		default:    w.data = '0;
	endcase
	case (cls)
		clsBcond: begin
			// Even codes test a condition, the odd code after it is the inverse
			case (cond[3:1])
				3'd0:    base = f.z;
				3'd1:    base = f.c;
				3'd2:    base = f.n;
				3'd3:    base = f.v;
				3'd4:    base = f.c & ~f.z;
				3'd5:    base = f.n ~^ f.v;
				3'd6:    base = ~f.z & (f.n ~^ f.v);
				default: base = 1'b1;
			endcase
			w.br = '{1'b1, (base ^ cond[0]) ? brCondTarget : brSequential, 1'b0};
		end
		clsB:       w.br = '{1'b1, brUncondTarget, 1'b0};
		clsBl:      w.br = '{1'b1, brLink, 1'b0};
		clsBx:      w.br = '{1'b1, brLink, 1'b1};
		clsUnknown: w.br = '0;
		default:    w.br = '{1'b0, brSequential, 1'b0};
	endcase
	return w;
endfunction

// Opcode bits per class, operand bits random
function automatic instrT buildInstr(input instrClassT cls, input condT cond);
	logic [31:0] r;
	instrT w;
	r = $random(seed);
	case (cls)
		clsMovs:    w = {5'b00100, r[10:0]};
		clsMov:     w = {9'b010001100, r[6:0]};
		clsAddsImm: w = {7'b0001110, r[8:0]};
		clsAddsReg: w = {7'b0001100, r[8:0]};
		clsAddSp:   w = {9'b101100000, r[6:0]};
		clsSubsImm: w = {7'b0001111, r[8:0]};
		clsSubsReg: w = {7'b0001101, r[8:0]};
		clsSubSp:   w = {9'b101100001, r[6:0]};
		clsCmp:     w = {10'b0100001010, r[5:0]};
		clsAnds:    w = {10'b0100000000, r[5:0]};
		clsEors:    w = {10'b0100000001, r[5:0]};
		clsOrrs:    w = {10'b0100001100, r[5:0]};
		clsMvns:    w = {10'b0100001111, r[5:0]};
		clsLsls:    w = {10'b0100000010, r[5:0]};
		clsLsrs:    w = {10'b0100000011, r[5:0]};
		clsAsrs:    w = {10'b0100000100, r[5:0]};
		clsRors:    w = {10'b0100000111, r[5:0]};
		clsStr:     w = {5'b01100, r[10:0]};
		clsLdr:     w = {5'b01101, r[10:0]};
		clsBcond:   w = {4'b1101, cond, r[7:0]};
		clsB:       w = {5'b11100, r[10:0]};
		clsBl:      w = {10'b0100010100, r[5:0]};
		clsBx:      w = {9'b010001110, r[6:0]};
		clsNoop:    w = {10'b1011111100, r[5:0]};
		default:    w = {10'b1111111111, r[5:0]};
	endcase
	return w;
endfunction

function automatic flagsT randFlags();
	logic [31:0] r;
	r = $random(seed);
	return r[3:0];
endfunction

task automatic applyAndCheck(input instrT w, input flagsT f, input ctrlWordT exp,
		input string msg);
	@(posedge clk);
	instr <= w;
	flags <= f;
	@(posedge clk);
	@(negedge clk);
	checkWord(exp, $sformatf("%s instr 0x%h flags %b", msg, w, f));
endtask

// New word on every edge, each checked one cycle after it is sampled
task automatic runStream(input string msg);
	int n;
	n = streamInstr.size();
	for (int i = 0; i <= n; i++) begin
		@(posedge clk);
		if (i < n) begin
			instr <= streamInstr[i];
			flags <= streamFlags[i];
		end
		@(negedge clk);
		if (i > 0) begin
			checkWord(streamExp[i - 1], $sformatf("%s word %0d instr 0x%h flags %b", msg,
				i - 1, streamInstr[i - 1], streamFlags[i - 1]));
		end
	end
	streamInstr.delete();
	streamFlags.delete();
	streamExp.delete();
endtask

task automatic resetTest();
	@(posedge clk);
	instr <= buildInstr(clsBl, condEq);
	flags <= 4'hF;
	repeat (resetCycles - 1) @(posedge clk);
	@(negedge clk);
	checkWord('0, "Outputs during reset");
	@(posedge clk);
	rstN <= 1'b1;
	@(negedge clk);
	checkWord('0, "Outputs right after reset");
endtask

task automatic dataTest();
	instrClassT cls;
	for (int i = int'(clsMovs); i <= int'(clsLdr); i++) begin
		cls = instrClassT'(i);
		repeat (2) begin
			applyAndCheck(buildInstr(cls, condEq), randFlags(),
				expectedWord(cls, condEq, '0), cls.name());
		end
	end
endtask

task automatic condTest();
	flagsT f;
	for (int c = 0; c < 15; c++) begin
		for (int k = 0; k < 16; k++) begin
			f = k[3:0];
			streamInstr.push_back(buildInstr(clsBcond, condT'(c)));
			streamFlags.push_back(f);
			streamExp.push_back(expectedWord(clsBcond, condT'(c), f));
		end
	end
	runStream("Bcond sweep");
endtask

task automatic branchTest();
	applyAndCheck(buildInstr(clsB, condEq), randFlags(), expectedWord(clsB, condEq, '0), "B");
	applyAndCheck(buildInstr(clsBl, condEq), randFlags(), expectedWord(clsBl, condEq, '0), "BL");
	applyAndCheck(buildInstr(clsBx, condEq), randFlags(), expectedWord(clsBx, condEq, '0), "BX");
	applyAndCheck(buildInstr(clsNoop, condEq), randFlags(),
		expectedWord(clsNoop, condEq, '0), "NOOP");
endtask

task automatic unknownTest();
	applyAndCheck(buildInstr(clsUnknown, condEq), randFlags(), '0, "Top bits all ones");
	applyAndCheck(buildInstr(clsBcond, 4'hF), randFlags(), '0, "Branch with cond 15");
	applyAndCheck(16'h0000, randFlags(), '0, "All-zero word");
endtask

task automatic backToBackTest();
	instrClassT mix[6] = '{clsAddsReg, clsLdr, clsBl, clsBcond, clsStr, clsBx};
	flagsT f;
	foreach (mix[i]) begin
		f = randFlags();
		streamInstr.push_back(buildInstr(mix[i], condGt));
		streamFlags.push_back(f);
		streamExp.push_back(expectedWord(mix[i], condGt, f));
	end
	runStream("Back to back");
endtask

`endif

// File: verification/cpuControlTb.sv
// Decode control unit testbench
`timescale 1ns/1ps
module cpuControlTb;

	import decodePkg::*;

	localparam int clkPeriod = 20;
	localparam int resetCycles = 3;
	// Tests take about 340 cycles, the cond sweep alone 241
	localparam int maxCycles = 400;

	typedef struct packed {
		dataCtrlT   data;
		branchCtrlT br;
	} ctrlWordT;

	logic       clk;
	logic       rstN;
	instrT      instr;
	flagsT      flags;
	dataCtrlT   dataCtrl;
	branchCtrlT branchCtrl;

	integer seed;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	// Words for the back-to-back streams
	instrT    streamInstr[$];
	flagsT    streamFlags[$];
	ctrlWordT streamExp[$];

	cpuControl dut (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.flags      (flags),
		.dataCtrl   (dataCtrl),
		.branchCtrl (branchCtrl)
	);

	always #(clkPeriod / 2) clk = ~clk;

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED at %0t: %s, got 0x%h, expected 0x%h",
				$time, msg, actual, expected);
		end
	endtask

	task automatic checkWord(input ctrlWordT exp, input string msg);
		checkValue(32'(dataCtrl), 32'(exp.data), {msg, ": dataCtrl"});
		checkValue(32'(branchCtrl), 32'(exp.br), {msg, ": branchCtrl"});
	endtask

	`include "controlTests.svh"

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > maxCycles) begin
			$display("Timeout: tests did not finish within %0d cycles", maxCycles);
			$display("Checks run: %0d, errors: %0d", checks, errors + 1);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		seed = 4973;
		clk = 1'b0;
		rstN = 1'b0;
		instr = '0;
		flags = '0;

		resetTest();
		dataTest();
		condTest();
		branchTest();
		unknownTest();
		backToBackTest();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+verification
hdl/decodePkg.sv
hdl/opcodeClassifier.sv
hdl/dataOpDecoder.sv
hdl/branchResolver.sv
hdl/cpuControl.sv
verification/cpuControlTb.sv
